// ==== rtl/mips_pkg.sv ====
package mips_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [31:0] RESET_PC = 32'hBFC0_0000;  // boot rom vector

    // primary opcode field in instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field of SPECIAL in instr[5:0]
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1
    } wb_sel_e;

    typedef enum logic [1:0] {
        FWD_ID  = 2'd0,  // value read in decode
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

endpackage

// ==== rtl/mips_decoder.sv ====
`timescale 1ns/1ps

module mips_decoder (
    input  logic [31:0]       instr_i,
    output mips_pkg::alu_op_e alu_op_o,
    output logic              src_b_imm_o,
    output logic              src_a_shamt_o,
    output logic              zero_ext_o,
    output logic              reg_wr_o,
    output logic              dst_rt_o,
    output mips_pkg::wb_sel_e wb_sel_o,
    output logic              mem_rd_o,
    output logic              mem_wr_o,
    output logic              branch_o,
    output logic              branch_ne_o,
    output logic              rs_used_o,
    output logic              rt_used_o
);

    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;

    assign opcode = mips_pkg::opcode_e'(instr_i[31:26]);
    assign funct  = mips_pkg::funct_e'(instr_i[5:0]);

    always_comb begin
        alu_op_o      = mips_pkg::ALU_ADD;
        src_b_imm_o   = 1'b0;
        src_a_shamt_o = 1'b0;
        zero_ext_o    = 1'b0;
        reg_wr_o      = 1'b0;
        dst_rt_o      = 1'b0;
        wb_sel_o      = mips_pkg::WB_ALU;
        mem_rd_o      = 1'b0;
        mem_wr_o      = 1'b0;
        branch_o      = 1'b0;
        branch_ne_o   = 1'b0;
        rs_used_o     = 1'b0;
        rt_used_o     = 1'b0;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                reg_wr_o  = 1'b1;  // rd destination
                rs_used_o = 1'b1;
                rt_used_o = 1'b1;
                case (funct)
                    mips_pkg::F_ADDU: alu_op_o = mips_pkg::ALU_ADD;
                    mips_pkg::F_SUBU: alu_op_o = mips_pkg::ALU_SUB;
                    mips_pkg::F_AND:  alu_op_o = mips_pkg::ALU_AND;
                    mips_pkg::F_OR:   alu_op_o = mips_pkg::ALU_OR;
                    mips_pkg::F_XOR:  alu_op_o = mips_pkg::ALU_XOR;
                    mips_pkg::F_SLT:  alu_op_o = mips_pkg::ALU_SLT;
                    mips_pkg::F_SLTU: alu_op_o = mips_pkg::ALU_SLTU;
                    mips_pkg::F_SLL, mips_pkg::F_SRL: begin
                        alu_op_o      = (funct == mips_pkg::F_SLL) ? mips_pkg::ALU_SLL
                                                                   : mips_pkg::ALU_SRL;
                        src_a_shamt_o = 1'b1;  // shift amount from instr[10:6]
                        rs_used_o     = 1'b0;
                    end
                    default: begin  // unknown funct acts as nop
                        reg_wr_o  = 1'b0;
                        rs_used_o = 1'b0;
                        rt_used_o = 1'b0;
                    end
                endcase
            end
            mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_ANDI, mips_pkg::OP_ORI: begin
                reg_wr_o    = 1'b1;
                dst_rt_o    = 1'b1;
                src_b_imm_o = 1'b1;
                rs_used_o   = 1'b1;
                zero_ext_o  = (opcode == mips_pkg::OP_ANDI) || (opcode == mips_pkg::OP_ORI);
                case (opcode)
                    mips_pkg::OP_SLTI: alu_op_o = mips_pkg::ALU_SLT;
                    mips_pkg::OP_ANDI: alu_op_o = mips_pkg::ALU_AND;
                    mips_pkg::OP_ORI:  alu_op_o = mips_pkg::ALU_OR;
                    default:           alu_op_o = mips_pkg::ALU_ADD;
                endcase
            end
            mips_pkg::OP_LUI: begin
                reg_wr_o    = 1'b1;
                dst_rt_o    = 1'b1;
                src_b_imm_o = 1'b1;
                alu_op_o    = mips_pkg::ALU_LUI;  // rs field ignored
            end
            mips_pkg::OP_LW: begin
                reg_wr_o    = 1'b1;
                dst_rt_o    = 1'b1;
                src_b_imm_o = 1'b1;
                wb_sel_o    = mips_pkg::WB_MEM;
                mem_rd_o    = 1'b1;
                rs_used_o   = 1'b1;
            end
            mips_pkg::OP_SW: begin
                src_b_imm_o = 1'b1;
                mem_wr_o    = 1'b1;
                rs_used_o   = 1'b1;
                rt_used_o   = 1'b1;  // store data
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                branch_o    = 1'b1;
                branch_ne_o = (opcode == mips_pkg::OP_BNE);
                rs_used_o   = 1'b1;
                rt_used_o   = 1'b1;
            end
            default: ;  // unknown opcode writes nothing
        endcase
    end

endmodule

// ==== rtl/mips_regfile.sv ====
`timescale 1ns/1ps

module mips_regfile (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic [mips_pkg::REG_AW-1:0] rs_i,
    input  logic [mips_pkg::REG_AW-1:0] rt_i,
    input  logic                        wr_en_i,
    input  logic [mips_pkg::REG_AW-1:0] wr_num_i,
    input  logic [mips_pkg::XLEN-1:0]   wr_data_i,
    output logic [mips_pkg::XLEN-1:0]   rs_data_o,
    output logic [mips_pkg::XLEN-1:0]   rt_data_o
);

    logic [mips_pkg::XLEN-1:0] regs_q [1:31];  // $0 has no storage

    function automatic logic [mips_pkg::XLEN-1:0] read_reg(
        input logic [mips_pkg::REG_AW-1:0] num
    );
        if (num == '0) return '0;
        if (wr_en_i && wr_num_i == num) return wr_data_i;  // write-back bypass
        return regs_q[num];
    endfunction

    always_comb begin
        rs_data_o = read_reg(rs_i);
        rt_data_o = read_reg(rt_i);
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && wr_num_i != '0) begin
            regs_q[wr_num_i] <= wr_data_i;
        end
    end

endmodule

// ==== rtl/mips_hazard_unit.sv ====
`timescale 1ns/1ps

module mips_hazard_unit (
    input  logic [mips_pkg::REG_AW-1:0] id_rs_i,
    input  logic [mips_pkg::REG_AW-1:0] id_rt_i,
    input  logic                        id_rs_used_i,
    input  logic                        id_rt_used_i,
    input  logic [mips_pkg::REG_AW-1:0] ex_rs_i,
    input  logic [mips_pkg::REG_AW-1:0] ex_rt_i,
    input  logic                        ex_mem_rd_i,
    input  logic [mips_pkg::REG_AW-1:0] ex_dst_i,
    input  logic                        mem_reg_wr_i,
    input  logic [mips_pkg::REG_AW-1:0] mem_dst_i,
    input  logic                        wb_reg_wr_i,
    input  logic [mips_pkg::REG_AW-1:0] wb_dst_i,
    output mips_pkg::fwd_sel_e          fwd_a_o,
    output mips_pkg::fwd_sel_e          fwd_b_o,
    output logic                        stall_o
);

    logic load_hit_rs;
    logic load_hit_rt;

    // youngest producer wins, so memory is checked last
    function automatic mips_pkg::fwd_sel_e pick_src(input logic [mips_pkg::REG_AW-1:0] src);
        mips_pkg::fwd_sel_e sel;
        sel = mips_pkg::FWD_ID;
        if (src != '0) begin
            if (wb_reg_wr_i && wb_dst_i == src) sel = mips_pkg::FWD_WB;
            if (mem_reg_wr_i && mem_dst_i == src) sel = mips_pkg::FWD_MEM;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a_o = pick_src(ex_rs_i);
        fwd_b_o = pick_src(ex_rt_i);
    end

    // load data is only ready in write-back so one bubble is needed
    assign load_hit_rs = id_rs_used_i && (id_rs_i == ex_dst_i);
    assign load_hit_rt = id_rt_used_i && (id_rt_i == ex_dst_i);
    assign stall_o     = ex_mem_rd_i && (ex_dst_i != '0) && (load_hit_rs || load_hit_rt);

endmodule

// ==== rtl/mips_alu.sv ====
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::alu_op_e         op_i,
    input  logic [mips_pkg::XLEN-1:0] a_i,
    input  logic [mips_pkg::XLEN-1:0] b_i,
    output logic [mips_pkg::XLEN-1:0] result_o
);

    always_comb begin
        case (op_i)
            mips_pkg::ALU_ADD:  result_o = a_i + b_i;
            mips_pkg::ALU_SUB:  result_o = a_i - b_i;
            mips_pkg::ALU_AND:  result_o = a_i & b_i;
            mips_pkg::ALU_OR:   result_o = a_i | b_i;
            mips_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            mips_pkg::ALU_SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            mips_pkg::ALU_SLTU: result_o = {31'b0, a_i < b_i};
            mips_pkg::ALU_SLL:  result_o = b_i << a_i[4:0];  // a carries shamt
            mips_pkg::ALU_SRL:  result_o = b_i >> a_i[4:0];
            mips_pkg::ALU_LUI:  result_o = {b_i[15:0], 16'h0000};
            default:            result_o = '0;
        endcase
    end

endmodule

// ==== rtl/mips_core.sv ====
`timescale 1ns/1ps

module mips_core (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    output logic                        inst_sram_en_o,
    output logic [mips_pkg::XLEN-1:0]   inst_sram_addr_o,
    input  logic [mips_pkg::XLEN-1:0]   inst_sram_rdata_i,
    output logic                        data_sram_en_o,
    output logic [3:0]                  data_sram_wen_o,
    output logic [mips_pkg::XLEN-1:0]   data_sram_addr_o,
    output logic [mips_pkg::XLEN-1:0]   data_sram_wdata_o,
    input  logic [mips_pkg::XLEN-1:0]   data_sram_rdata_i,
    output logic [mips_pkg::XLEN-1:0]   debug_wb_pc_o,
    output logic [3:0]                  debug_wb_rf_wen_o,
    output logic [mips_pkg::REG_AW-1:0] debug_wb_rf_wnum_o,
    output logic [mips_pkg::XLEN-1:0]   debug_wb_rf_wdata_o
);

    localparam int XW = mips_pkg::XLEN;
    localparam int RW = mips_pkg::REG_AW;

    logic          started_q, redirect_q, id_valid_q, hold_q, stall, id_kill;
    logic [XW-1:0] pc_q, target_q, hold_instr_q, id_instr, id_imm, rf_rs_data, rf_rt_data;
    logic [RW-1:0] id_rs, id_rt, id_rd;

    mips_pkg::alu_op_e  dec_alu_op;
    mips_pkg::wb_sel_e  dec_wb_sel;
    mips_pkg::fwd_sel_e fwd_a, fwd_b;
    logic dec_src_b_imm, dec_src_a_shamt, dec_zero_ext, dec_reg_wr, dec_dst_rt;
    logic dec_mem_rd, dec_mem_wr, dec_branch, dec_branch_ne, dec_rs_used, dec_rt_used;

    logic [XW-1:0] ex_pc_q, ex_a_q, ex_b_q, ex_imm_q;
    logic [RW-1:0] ex_rs_q, ex_rt_q, ex_dst_q;
    logic          ex_src_b_imm_q, ex_src_a_shamt_q, ex_reg_wr_q, ex_mem_rd_q, ex_mem_wr_q;
    logic          ex_branch_q, ex_branch_ne_q, ex_taken;
    logic [XW-1:0] ex_fwd_a, ex_fwd_b, alu_a, alu_b, ex_alu_result, ex_target;
    mips_pkg::alu_op_e ex_alu_op_q;
    mips_pkg::wb_sel_e ex_wb_sel_q, mem_wb_sel_q;

    logic [XW-1:0] mem_pc_q, mem_alu_q, wb_pc_q, wb_result_q;
    logic [RW-1:0] mem_dst_q, wb_dst_q;
    logic          mem_reg_wr_q, wb_reg_wr_q;

    // fetch; pc_q is the address of the word now in decode
    assign inst_sram_en_o   = started_q & ~stall;
    assign inst_sram_addr_o = redirect_q ? target_q : pc_q + 32'd4;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            started_q    <= 1'b0;
            pc_q         <= mips_pkg::RESET_PC - 32'd4;  // first next-pc is the vector
            redirect_q   <= 1'b0;
            target_q     <= '0;
            id_valid_q   <= 1'b0;
            hold_q       <= 1'b0;
            hold_instr_q <= '0;
        end else begin
            started_q  <= 1'b1;
            redirect_q <= ex_taken;
            target_q   <= ex_target;
            hold_q     <= stall;
            if (inst_sram_en_o) pc_q <= inst_sram_addr_o;
            if (stall) hold_instr_q <= id_instr;  // sram idle while stalled
            else id_valid_q <= inst_sram_en_o & ~ex_taken;  // kill wrong-path word
        end
    end

    // decode
    assign id_instr = hold_q ? hold_instr_q : inst_sram_rdata_i;
    assign id_rs    = id_instr[25:21];
    assign id_rt    = id_instr[20:16];
    assign id_rd    = id_instr[15:11];
    assign id_imm   = dec_zero_ext ? {16'h0000, id_instr[15:0]}
                                   : {{16{id_instr[15]}}, id_instr[15:0]};
    assign id_kill  = stall | ~id_valid_q;

    mips_decoder u_decoder (
        .instr_i(id_instr), .alu_op_o(dec_alu_op), .src_b_imm_o(dec_src_b_imm),
        .src_a_shamt_o(dec_src_a_shamt), .zero_ext_o(dec_zero_ext), .reg_wr_o(dec_reg_wr),
        .dst_rt_o(dec_dst_rt), .wb_sel_o(dec_wb_sel), .mem_rd_o(dec_mem_rd),
        .mem_wr_o(dec_mem_wr), .branch_o(dec_branch), .branch_ne_o(dec_branch_ne),
        .rs_used_o(dec_rs_used), .rt_used_o(dec_rt_used)
    );

    mips_regfile u_regfile (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .rs_i(id_rs), .rt_i(id_rt),
        .wr_en_i(wb_reg_wr_q), .wr_num_i(wb_dst_q), .wr_data_i(wb_result_q),
        .rs_data_o(rf_rs_data), .rt_data_o(rf_rt_data)
    );

    mips_hazard_unit u_hazard (
        .id_rs_i(id_rs), .id_rt_i(id_rt),
        .id_rs_used_i(dec_rs_used & id_valid_q), .id_rt_used_i(dec_rt_used & id_valid_q),
        .ex_rs_i(ex_rs_q), .ex_rt_i(ex_rt_q), .ex_mem_rd_i(ex_mem_rd_q), .ex_dst_i(ex_dst_q),
        .mem_reg_wr_i(mem_reg_wr_q), .mem_dst_i(mem_dst_q),
        .wb_reg_wr_i(wb_reg_wr_q), .wb_dst_i(wb_dst_q),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .stall_o(stall)
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_pc_q <= '0;
            ex_rs_q <= '0;
            ex_rt_q <= '0;
            ex_dst_q <= '0;
            ex_a_q <= '0;
            ex_b_q <= '0;
            ex_imm_q <= '0;
            ex_alu_op_q <= mips_pkg::ALU_ADD;
            ex_wb_sel_q <= mips_pkg::WB_ALU;
            ex_src_b_imm_q <= 1'b0;
            ex_src_a_shamt_q <= 1'b0;
            ex_reg_wr_q <= 1'b0;
            ex_mem_rd_q <= 1'b0;
            ex_mem_wr_q <= 1'b0;
            ex_branch_q <= 1'b0;
            ex_branch_ne_q <= 1'b0;
        end else begin
            ex_pc_q          <= pc_q;
            ex_rs_q          <= id_rs;
            ex_rt_q          <= id_rt;
            ex_dst_q         <= dec_dst_rt ? id_rt : id_rd;
            ex_a_q           <= rf_rs_data;
            ex_b_q           <= rf_rt_data;
            ex_imm_q         <= id_imm;
            ex_alu_op_q      <= dec_alu_op;
            ex_wb_sel_q      <= dec_wb_sel;
            ex_src_b_imm_q   <= dec_src_b_imm;
            ex_src_a_shamt_q <= dec_src_a_shamt;
            ex_reg_wr_q      <= dec_reg_wr & ~id_kill;  // bubble on stall or empty slot
            ex_mem_rd_q      <= dec_mem_rd & ~id_kill;
            ex_mem_wr_q      <= dec_mem_wr & ~id_kill;
            ex_branch_q      <= dec_branch & ~id_kill;
            ex_branch_ne_q   <= dec_branch_ne;
        end
    end

    // execute
    function automatic logic [XW-1:0] fwd_value(input mips_pkg::fwd_sel_e sel,
                                                 input logic [XW-1:0] id_val);
        case (sel)
            mips_pkg::FWD_MEM: return mem_alu_q;
            mips_pkg::FWD_WB:  return wb_result_q;
            default:           return id_val;
        endcase
    endfunction

    always_comb begin
        ex_fwd_a = fwd_value(fwd_a, ex_a_q);
        ex_fwd_b = fwd_value(fwd_b, ex_b_q);
    end

    assign alu_a     = ex_src_a_shamt_q ? {27'b0, ex_imm_q[10:6]} : ex_fwd_a;  // shamt field
    assign alu_b     = ex_src_b_imm_q ? ex_imm_q : ex_fwd_b;
    assign ex_taken  = ex_branch_q & ((ex_fwd_a == ex_fwd_b) ^ ex_branch_ne_q);
    assign ex_target = ex_pc_q + 32'd4 + {ex_imm_q[29:0], 2'b00};  // relative to delay slot

    mips_alu u_alu (.op_i(ex_alu_op_q), .a_i(alu_a), .b_i(alu_b), .result_o(ex_alu_result));

    assign data_sram_en_o    = ex_mem_rd_q | ex_mem_wr_q;
    assign data_sram_wen_o   = {4{ex_mem_wr_q}};
    assign data_sram_addr_o  = ex_alu_result;
    assign data_sram_wdata_o = ex_fwd_b;

    // memory and write-back
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_pc_q     <= '0;
            mem_dst_q    <= '0;
            mem_alu_q    <= '0;
            mem_wb_sel_q <= mips_pkg::WB_ALU;
            mem_reg_wr_q <= 1'b0;
            wb_pc_q      <= '0;
            wb_dst_q     <= '0;
            wb_result_q  <= '0;
            wb_reg_wr_q  <= 1'b0;
        end else begin
            mem_pc_q     <= ex_pc_q;
            mem_dst_q    <= ex_dst_q;
            mem_alu_q    <= ex_alu_result;
            mem_wb_sel_q <= ex_wb_sel_q;
            mem_reg_wr_q <= ex_reg_wr_q;
            wb_pc_q      <= mem_pc_q;
            wb_dst_q     <= mem_dst_q;
            wb_reg_wr_q  <= mem_reg_wr_q;
            wb_result_q  <= (mem_wb_sel_q == mips_pkg::WB_MEM) ? data_sram_rdata_i : mem_alu_q;
        end
    end

    assign debug_wb_pc_o       = wb_pc_q;
    assign debug_wb_rf_wen_o   = {4{wb_reg_wr_q && wb_dst_q != '0}};
    assign debug_wb_rf_wnum_o  = wb_dst_q;
    assign debug_wb_rf_wdata_o = wb_result_q;

endmodule

// ==== dv/mips_core_checker.sv ====
`timescale 1ns/1ps

module mips_core_checker (
    input logic        clk_i,
    input logic        arst_n_i,
    input logic        inst_en_i,
    input logic [31:0] inst_addr_i,
    input logic        data_en_i,
    input logic [3:0]  data_wen_i,
    input logic [3:0]  trace_wen_i,
    input logic [4:0]  trace_wnum_i
);

    int fail_count = 0;

    // both sram ports stay quiet while reset is held
    reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !inst_en_i && !data_en_i)
        else begin
            $error("sram enable active during reset");
            fail_count++;
        end

    wen_with_en: assert property (@(posedge clk_i) data_wen_i != 4'h0 |-> data_en_i)
        else begin
            $error("data write strobe without enable");
            fail_count++;
        end

    no_trace_r0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                  trace_wen_i != 4'h0 |-> trace_wnum_i != 5'd0)
        else begin
            $error("trace write reported for register zero");
            fail_count++;
        end

    fetch_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                    inst_en_i |-> inst_addr_i[1:0] == 2'b00)
        else begin
            $error("misaligned instruction fetch");
            fail_count++;
        end

endmodule

bind mips_core mips_core_checker u_checker (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .inst_en_i(inst_sram_en_o),
    .inst_addr_i(inst_sram_addr_o),
    .data_en_i(data_sram_en_o),
    .data_wen_i(data_sram_wen_o),
    .trace_wen_i(debug_wb_rf_wen_o),
    .trace_wnum_i(debug_wb_rf_wnum_o)
);

// ==== dv/tb_mips_core.sv ====
`timescale 1ns/1ps

module tb_mips_core;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 10;
    localparam int SETTLE       = 12;  // idle cycles after the last expected write

    logic        clk_i = 1'b0;
    logic        arst_n_i;
    logic        inst_sram_en_o;
    logic [31:0] inst_sram_addr_o;
    logic [31:0] inst_sram_rdata_i;
    logic        data_sram_en_o;
    logic [3:0]  data_sram_wen_o;
    logic [31:0] data_sram_addr_o;
    logic [31:0] data_sram_wdata_o;
    logic [31:0] data_sram_rdata_i;
    logic [31:0] debug_wb_pc_o;
    logic [3:0]  debug_wb_rf_wen_o;
    logic [4:0]  debug_wb_rf_wnum_o;
    logic [31:0] debug_wb_rf_wdata_o;

    logic [31:0] imem [0:1023];  // 4 KiB window at the reset vector
    logic [31:0] dmem [0:255];
    logic [31:0] sh_reg [0:31];
    logic [31:0] sh_mem [0:255];
    logic [31:0] prog [$];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_num [$];
    logic [31:0] exp_val [$];
    logic [31:0] ref_pc, ref_npc;
    logic [4:0]  last_dst;
    logic        inst_pend = 1'b0;
    logic        data_pend = 1'b0;
    logic        first_fetch = 1'b0;
    logic [9:0]  inst_idx;
    logic [7:0]  data_idx;
    integer      seed = 32'h07b16381;
    int          errors, checks, tests, cycles;
    int          cycle_limit = 50;  // slack before the first test adds its budget

    mips_core UUT (.*);

    always #HALF_PERIOD clk_i = ~clk_i;

    function automatic logic [31:0] enc_r(input logic [5:0] funct,
                                          input logic [4:0] rs, rt, rd, sh);
        return {6'h00, rs, rt, rd, sh, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], 16'h0000} ^ ~addr;
    endfunction

    // one instruction of the architectural model with the delay slot kept in ref_npc
    function automatic void ref_step(input logic [31:0] instr);
        logic [31:0] a, b, simm, zimm, addr, val, target;
        logic [4:0]  dst;
        logic        wr, taken;
        a     = sh_reg[instr[25:21]];
        b     = sh_reg[instr[20:16]];
        simm  = {{16{instr[15]}}, instr[15:0]};
        zimm  = {16'h0000, instr[15:0]};
        addr  = a + simm;
        dst   = instr[20:16];
        wr    = 1'b1;
        taken = 1'b0;
        val   = '0;
        case (instr[31:26])
            mips_pkg::OP_SPECIAL: begin
                dst = instr[15:11];
                case (instr[5:0])
                    mips_pkg::F_ADDU: val = a + b;
                    mips_pkg::F_SUBU: val = a - b;
                    mips_pkg::F_AND:  val = a & b;
                    mips_pkg::F_OR:   val = a | b;
                    mips_pkg::F_XOR:  val = a ^ b;
                    mips_pkg::F_SLT:  val = {31'b0, $signed(a) < $signed(b)};
                    mips_pkg::F_SLTU: val = {31'b0, a < b};
                    mips_pkg::F_SLL:  val = b << instr[10:6];
                    mips_pkg::F_SRL:  val = b >> instr[10:6];
                    default:          wr = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: val = a + simm;
            mips_pkg::OP_SLTI:  val = {31'b0, $signed(a) < $signed(simm)};
            mips_pkg::OP_ANDI:  val = a & zimm;
            mips_pkg::OP_ORI:   val = a | zimm;
            mips_pkg::OP_LUI:   val = {instr[15:0], 16'h0000};
            mips_pkg::OP_LW:    val = sh_mem[addr[9:2]];
            mips_pkg::OP_SW: begin
                wr = 1'b0;
                sh_mem[addr[9:2]] = b;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                wr    = 1'b0;
                taken = (a == b) ^ (instr[31:26] == mips_pkg::OP_BNE);
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0) begin
            sh_reg[dst] = val;
            exp_pc.push_back(ref_pc);
            exp_num.push_back(32'(dst));
            exp_val.push_back(val);
        end
        target  = ref_pc + 32'd4 + (simm << 2);
        ref_pc  = ref_npc;
        ref_npc = taken ? target : ref_npc + 32'd4;
    endfunction

    function automatic logic [4:0] pick_reg(input bit zero_ok);
        int r;
        r = $random(seed) & 15;
        if (r < 6) return last_dst;  // lean on the newest result
        if (zero_ok && r > 12) return 5'd0;
        return 5'd1 + 5'(r & 7);
    endfunction

    function automatic logic [31:0] rand_alu(input bit zero_ok);
        mips_pkg::funct_e  fns [9] = '{mips_pkg::F_ADDU, mips_pkg::F_SUBU, mips_pkg::F_AND,
                                       mips_pkg::F_OR, mips_pkg::F_XOR, mips_pkg::F_SLT,
                                       mips_pkg::F_SLTU, mips_pkg::F_SLL, mips_pkg::F_SRL};
        mips_pkg::opcode_e ops [5] = '{mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_ANDI,
                                       mips_pkg::OP_ORI, mips_pkg::OP_LUI};
        logic [4:0]  rs, rt, rd;
        logic [15:0] imm;
        int          kind;
        rs   = pick_reg(zero_ok);
        rt   = pick_reg(zero_ok);
        rd   = pick_reg(zero_ok);
        imm  = 16'($random(seed));
        kind = {$random(seed)} % 14;
        if (kind < 9) begin
            last_dst = rd;
            if (kind >= 7) return enc_r(fns[kind], 5'd0, rt, rd, imm[4:0]);  // shifts
            return enc_r(fns[kind], rs, rt, rd, 5'd0);
        end
        last_dst = rt;
        return enc_i(ops[kind - 9], rs, rt, imm);
    endfunction

    task automatic emit_imm(input logic [5:0] op, input logic [4:0] rs, input logic [15:0] imm);
        logic [4:0] rt;
        rt = pick_reg(1'b0);
        prog.push_back(enc_i(op, rs, rt, imm));
        last_dst = rt;
    endtask

    task automatic start_program();
        prog.delete();
        last_dst = 5'd1;
    endtask

    task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("ERR %0t %s expected %h actual %h", $time, sig, exp, act);
            errors++;
        end
    endtask

    // sram models take the request just ahead of the rising edge and answer on the falling one
    always begin
        @(negedge clk_i);
        if (inst_pend) inst_sram_rdata_i = imem[inst_idx];
        if (data_pend) data_sram_rdata_i = dmem[data_idx];
        #(HALF_PERIOD - 1);
        inst_pend = inst_sram_en_o;
        inst_idx  = inst_sram_addr_o[11:2];
        data_pend = data_sram_en_o;
        data_idx  = data_sram_addr_o[9:2];
        if (data_sram_en_o && data_sram_wen_o == 4'hf) dmem[data_idx] = data_sram_wdata_o;
        if (inst_sram_en_o && first_fetch) begin
            first_fetch = 1'b0;
            check_value("inst_sram_addr_o", mips_pkg::RESET_PC, inst_sram_addr_o);
        end
    end

    // trace outputs come straight from write-back flops
    always @(negedge clk_i) begin
        if (debug_wb_rf_wen_o != 4'h0) begin
            if (exp_pc.size() == 0) begin
                $display("unexpected register write at %0t from pc %h", $time, debug_wb_pc_o);
                errors++;
            end else begin
                check_value("debug_wb_rf_wen_o", 32'hf, 32'(debug_wb_rf_wen_o));
                check_value("debug_wb_pc_o", exp_pc.pop_front(), debug_wb_pc_o);
                check_value("debug_wb_rf_wnum_o", exp_num.pop_front(), 32'(debug_wb_rf_wnum_o));
                check_value("debug_wb_rf_wdata_o", exp_val.pop_front(), debug_wb_rf_wdata_o);
            end
        end
    end

    initial begin
        while (cycles <= cycle_limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d trace writes still missing",
                 cycles, exp_pc.size());
        $display("Errors found");
        $finish;
    end

    task automatic run_test(input string name);
        int          start_errors;
        int          writes;
        int          steps;
        logic [31:0] end_pc;
        start_errors = errors;
        end_pc = mips_pkg::RESET_PC + 32'(4 * prog.size());
        prog.push_back(enc_i(mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'hffff));  // spin on itself
        prog.push_back(32'h0000_0000);
        arst_n_i = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 32'h0000_0000;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i]   = fill_word(32'(i * 4));
            sh_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            sh_reg[i] = '0;
        end
        ref_pc  = mips_pkg::RESET_PC;
        ref_npc = mips_pkg::RESET_PC + 32'd4;
        steps   = 0;
        while (ref_pc != end_pc && steps < 4 * prog.size()) begin
            ref_step(imem[ref_pc[11:2]]);
            steps++;
        end
        writes = exp_pc.size();
        cycle_limit += RESET_CYCLES + SETTLE + 4 * prog.size() + 50;
        repeat (RESET_CYCLES) @(negedge clk_i);
        first_fetch = 1'b1;
        arst_n_i    = 1'b1;
        while (exp_pc.size() != 0) @(negedge clk_i);
        repeat (SETTLE) @(negedge clk_i);
        for (int i = 0; i < 256; i++) begin
            check_value($sformatf("dmem[%0d]", i), sh_mem[i], dmem[i]);
        end
        tests++;
        $display("test %0d %s: %0d writes traced, %0d errors",
                 tests, name, writes, errors - start_errors);
    endtask

    initial begin
        logic [4:0]  rs, rt;
        logic [15:0] addr;
        arst_n_i          = 1'b0;
        inst_sram_rdata_i = '0;
        data_sram_rdata_i = '0;
        @(negedge clk_i);

        start_program();
        repeat (80) prog.push_back(rand_alu(1'b0));
        run_test("alu_random");

        start_program();
        repeat (8) begin
            emit_imm(mips_pkg::OP_LUI, 5'd0, 16'($random(seed)));
            emit_imm(mips_pkg::OP_ORI, last_dst, 16'($random(seed)) | 16'h8000);
            emit_imm(mips_pkg::OP_ANDI, last_dst, 16'($random(seed)) | 16'h8000);
            emit_imm(mips_pkg::OP_ADDIU, last_dst, 16'($random(seed)) | 16'h8000);
            emit_imm(mips_pkg::OP_SLTI, last_dst, 16'($random(seed)) | 16'h8000);
        end
        run_test("immediates");

        start_program();
        repeat (4) prog.push_back(rand_alu(1'b0));
        repeat (12) begin
            addr = 16'(({$random(seed)} % 256) * 4);
            prog.push_back(rand_alu(1'b0));
            prog.push_back(enc_i(mips_pkg::OP_SW, 5'd0, pick_reg(1'b0), addr));
            emit_imm(mips_pkg::OP_LW, 5'd0, addr);  // reads back the store
            prog.push_back(enc_r(mips_pkg::F_ADDU, last_dst, pick_reg(1'b0), pick_reg(1'b0), 5'd0));
            emit_imm(mips_pkg::OP_LW, 5'd0, 16'(({$random(seed)} % 256) * 4));
            prog.push_back(enc_r(mips_pkg::F_SUBU, pick_reg(1'b0), last_dst, pick_reg(1'b0), 5'd0));
        end
        run_test("load_store");

        start_program();
        repeat (4) prog.push_back(rand_alu(1'b0));
        repeat (12) begin
            rs = pick_reg(1'b0);
            rt = ($random(seed) & 1) ? rs : pick_reg(1'b0);
            prog.push_back(enc_i((($random(seed) & 2) != 0) ? mips_pkg::OP_BNE : mips_pkg::OP_BEQ,
                                 rs, rt, 16'd2));
            repeat (3) prog.push_back(rand_alu(1'b0));  // delay slot, skipped word, target
        end
        run_test("branches");

        start_program();
        repeat (60) prog.push_back(rand_alu(1'b1));
        run_test("zero_register");

        errors += UUT.u_checker.fail_count;
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/mips_pkg.sv
rtl/mips_decoder.sv
rtl/mips_regfile.sv
rtl/mips_hazard_unit.sv
rtl/mips_alu.sv
rtl/mips_core.sv
dv/mips_core_checker.sv
dv/tb_mips_core.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - rtl/mips_pkg.sv
  - rtl/mips_decoder.sv
  - rtl/mips_regfile.sv
  - rtl/mips_hazard_unit.sv
  - rtl/mips_alu.sv
  - rtl/mips_core.sv
  - target: simulation
    files:
      - dv/mips_core_checker.sv
      - dv/tb_mips_core.sv
